// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := tb_pipe_trace
FILELIST := src.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== hw/pipe_pkg.sv ====
/*
 * pipeline shape shared by the trace unit
 * five in-order stages, tags declared at the widest legal width
 * only the low TAG_W bits of a tag carry meaning
 */
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////
    // stage naming
    //////////////////////////////////////////////////

    // encodings double as indices into the per-stage arrays
    typedef enum logic [2:0] {
        STG_F = 3'd0,
        STG_D = 3'd1,
        STG_E = 3'd2,
        STG_M = 3'd3,
        STG_W = 3'd4
    } stage_e;

    localparam int NUM_STAGES = 5;

    //////////////////////////////////////////////////
    // instruction tags
    //////////////////////////////////////////////////

    // up to five tags live at once, so 3 bits is the floor
    localparam int TAG_W_MIN = 3;
    localparam int TAG_W_MAX = 8;

    // upper bits stay zero when TAG_W < TAG_W_MAX
    typedef logic [TAG_W_MAX-1:0] tag_t;

endpackage

`default_nettype wire

// ==== hw/pipe_trace_top.sv ====
/*
 * pipeline trace unit, stall and flush are sampled every edge
 * records are one-cycle strobes with no back-pressure
 * TAG_W must be 3..8
 */
`timescale 1ns/1ns
`default_nettype none

module pipe_trace_top import pipe_pkg::*; import trace_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    output logic       rec_valid,
    output tag_t       rec_tag,
    output cyc_t       rec_fetch_cyc,
    output cyc_t       rec_decode_cyc,
    output cyc_t       rec_exec_cyc,
    output cyc_t       rec_mem_cyc,
    output cyc_t       rec_wb_cyc,
    output logic [7:0] rec_stall_cyc,
    output cnt_t       retired_cnt,
    output cnt_t       stall_cnt,
    output cnt_t       flush_cnt
);

    trace_rec_t rec;

    // reject tag widths that cannot hold five live tags
    if (TAG_W < TAG_W_MIN || TAG_W > TAG_W_MAX) begin : g_tag_w_check
        $error("TAG_W out of range");
    end

    stage_if st ();

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    stage_tracker #(.TAG_W(TAG_W)) u_tracker (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .st    (st.tracker)
    );

    stamp_store #(.TAG_W(TAG_W)) u_store (
        .clk       (clk),
        .rst       (rst),
        .st        (st.store),
        .rec_valid (rec_valid),
        .rec       (rec)
    );

    trace_stats u_stats (
        .clk         (clk),
        .rst         (rst),
        .st          (st.stats),
        .rec_valid   (rec_valid),
        .retired_cnt (retired_cnt),
        .stall_cnt   (stall_cnt),
        .flush_cnt   (flush_cnt)
    );

    // record fields flattened onto plain outputs
    assign rec_tag        = rec.tag;
    assign rec_fetch_cyc  = rec.fetch_cyc;
    assign rec_decode_cyc = rec.decode_cyc;
    assign rec_exec_cyc   = rec.exec_cyc;
    assign rec_mem_cyc    = rec.mem_cyc;
    assign rec_wb_cyc     = rec.wb_cyc;
    assign rec_stall_cyc  = rec.stall_cyc;

endmodule

`default_nettype wire

// ==== hw/stage_if.sv ====
/*
 * per-stage view of the pipeline, driven by the tracker
 * no handshake, every signal is a level or strobe valid each cycle
 */
`timescale 1ns/1ns
`default_nettype none

interface stage_if import pipe_pkg::*; import trace_pkg::*; ();

    // stage holds a live instruction this cycle
    logic [NUM_STAGES-1:0] occ;
    // tag of the stage content, stale when occ is low
    tag_t                  tag [NUM_STAGES];
    // stage took in a new instruction this cycle
    logic [NUM_STAGES-1:0] enter;
    // fetch and decode hold on the coming edge
    logic                  hold_fd;
    // number of live instructions dropped on the coming edge
    logic [1:0]            kill_fd;
    // running cycle count, 0 in the first cycle out of reset
    cyc_t                  cyc;

    modport tracker (
        output occ, tag, enter, hold_fd, kill_fd, cyc
    );

    modport store (
        input occ, tag, enter, hold_fd, kill_fd, cyc
    );

    // stats only needs the stall and flush conditions
    modport stats (
        input hold_fd, kill_fd
    );

endinterface

`default_nettype wire

// ==== hw/stage_tracker.sv ====
/*
 * follows occupancy and tags through F D E M W
 * flush wins over stall; a flush empties F and D, fetch refills next edge
 * tags are never reused until they wrap at 2^TAG_W
 */
`timescale 1ns/1ns
`default_nettype none

module stage_tracker import pipe_pkg::*; import trace_pkg::*; #(
    parameter int TAG_W = 4
) (
    input logic      clk,
    input logic      rst,
    input logic      stall,
    input logic      flush,
    stage_if.tracker st
);

    localparam tag_t TAG_MASK = tag_t'((1 << TAG_W) - 1);
    // fetch alone is live out of reset
    localparam logic [NUM_STAGES-1:0] FETCH_ONLY = NUM_STAGES'(1) << STG_F;

    cyc_t                  cyc_q;
    tag_t                  next_tag_q;
    logic [NUM_STAGES-1:0] occ_q;
    logic [NUM_STAGES-1:0] enter_q;
    tag_t                  tag_q [NUM_STAGES];
    logic                  dup_tag;

    //////////////////////////////////////////////////
    // stage registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q      <= '0;
            next_tag_q <= tag_t'(1);
            occ_q      <= FETCH_ONLY;
            enter_q    <= FETCH_ONLY;
            // first fetched instruction carries tag 0
            tag_q[STG_F] <= '0;
        end else begin
            cyc_q <= cyc_q + cyc_t'(1);

            // memory and write-back always advance
            occ_q[STG_W]   <= occ_q[STG_M];
            tag_q[STG_W]   <= tag_q[STG_M];
            enter_q[STG_W] <= occ_q[STG_M];
            occ_q[STG_M]   <= occ_q[STG_E];
            tag_q[STG_M]   <= tag_q[STG_E];
            enter_q[STG_M] <= occ_q[STG_E];

            if (flush) begin
                // drop F and D, bubble into E
                occ_q[STG_F]   <= 1'b0;
                occ_q[STG_D]   <= 1'b0;
                occ_q[STG_E]   <= 1'b0;
                enter_q[STG_F] <= 1'b0;
                enter_q[STG_D] <= 1'b0;
                enter_q[STG_E] <= 1'b0;
            end else if (stall) begin
                // F and D keep contents, E gets a bubble
                occ_q[STG_E]   <= 1'b0;
                enter_q[STG_F] <= 1'b0;
                enter_q[STG_D] <= 1'b0;
                enter_q[STG_E] <= 1'b0;
            end else begin
                occ_q[STG_F]   <= 1'b1;
                tag_q[STG_F]   <= next_tag_q;
                enter_q[STG_F] <= 1'b1;
                next_tag_q     <= (next_tag_q + tag_t'(1)) & TAG_MASK;
                occ_q[STG_D]   <= occ_q[STG_F];
                tag_q[STG_D]   <= tag_q[STG_F];
                enter_q[STG_D] <= occ_q[STG_F];
                occ_q[STG_E]   <= occ_q[STG_D];
                tag_q[STG_E]   <= tag_q[STG_D];
                enter_q[STG_E] <= occ_q[STG_D];
            end
        end
    end

    //////////////////////////////////////////////////
    // interface drive
    //////////////////////////////////////////////////

    assign st.occ   = occ_q;
    assign st.tag   = tag_q;
    assign st.enter = enter_q;
    assign st.cyc   = cyc_q;

    // a stall under flush is not a hold
    assign st.hold_fd = stall & ~flush;
    // only live F and D contents count as killed
    assign st.kill_fd = flush ? ({1'b0, occ_q[STG_F]} + {1'b0, occ_q[STG_D]}) : 2'd0;

    // pairwise tag compare over live stages
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < NUM_STAGES; i++) begin
            for (int j = i + 1; j < NUM_STAGES; j++) begin
                if (occ_q[i] && occ_q[j] && (tag_q[i] == tag_q[j])) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    a_unique_tags: assert property (@(posedge clk) disable iff (rst) !dup_tag)
        else $error("two live stages share a tag");

    // a flush leaves fetch and decode empty even under stall
    a_no_hold_on_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!occ_q[STG_F] && !occ_q[STG_D]))
        else $error("fetch or decode kept its content through a flush");

endmodule

`default_nettype wire

// ==== hw/stamp_store.sv ====
/*
 * per-tag stamp table, 2^TAG_W entries, no reset on the table itself
 * an entry is cleared when its tag enters fetch
 * the record leaves one cycle after the write-back cycle
 */
`timescale 1ns/1ns
`default_nettype none

module stamp_store import pipe_pkg::*; import trace_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic       clk,
    input  logic       rst,
    stage_if.store     st,
    output logic       rec_valid,
    output trace_rec_t rec
);

    localparam int   DEPTH    = 1 << TAG_W;
    localparam tag_t TAG_MASK = tag_t'(DEPTH - 1);

    trace_rec_t       tbl [DEPTH];
    logic [TAG_W-1:0] idx_f;
    logic [TAG_W-1:0] idx_d;
    logic [TAG_W-1:0] idx_e;
    logic [TAG_W-1:0] idx_m;
    logic [TAG_W-1:0] idx_w;
    trace_rec_t       rec_d;
    logic [DEPTH-1:0] killed_q;
    tag_t             exp_tag_q;

    // held-edge count sticks at 255
    function automatic logic [7:0] stall_inc(input logic [7:0] cur);
        stall_inc = (cur == 8'hff) ? cur : cur + 8'd1;
    endfunction

    assign idx_f = st.tag[STG_F][TAG_W-1:0];
    assign idx_d = st.tag[STG_D][TAG_W-1:0];
    assign idx_e = st.tag[STG_E][TAG_W-1:0];
    assign idx_m = st.tag[STG_M][TAG_W-1:0];
    assign idx_w = st.tag[STG_W][TAG_W-1:0];

    //////////////////////////////////////////////////
    // table writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (st.enter[STG_F]) begin
            // fresh entry, a hold in the same cycle already counts
            tbl[idx_f].tag        <= st.tag[STG_F];
            tbl[idx_f].fetch_cyc  <= st.cyc;
            tbl[idx_f].decode_cyc <= '0;
            tbl[idx_f].exec_cyc   <= '0;
            tbl[idx_f].mem_cyc    <= '0;
            tbl[idx_f].wb_cyc     <= '0;
            tbl[idx_f].stall_cyc  <= st.hold_fd ? 8'd1 : 8'd0;
        end else if (st.hold_fd && st.occ[STG_F]) begin
            tbl[idx_f].stall_cyc <= stall_inc(tbl[idx_f].stall_cyc);
        end

        if (st.enter[STG_D]) begin
            tbl[idx_d].decode_cyc <= st.cyc;
        end
        if (st.hold_fd && st.occ[STG_D]) begin
            tbl[idx_d].stall_cyc <= stall_inc(tbl[idx_d].stall_cyc);
        end

        if (st.enter[STG_E]) begin
            tbl[idx_e].exec_cyc <= st.cyc;
        end
        if (st.enter[STG_M]) begin
            tbl[idx_m].mem_cyc <= st.cyc;
        end
    end

    //////////////////////////////////////////////////
    // record out
    //////////////////////////////////////////////////

    // write-back lasts one cycle, so its stamp bypasses the table
    always_comb begin
        rec_d        = tbl[idx_w];
        rec_d.wb_cyc = st.cyc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= st.occ[STG_W];
        end
    end

    always_ff @(posedge clk) begin
        if (st.occ[STG_W]) begin
            rec <= rec_d;
        end
    end

    //////////////////////////////////////////////////
    // retirement order check
    //////////////////////////////////////////////////

    // killed tags are marked and stepped over one per idle cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            killed_q  <= '0;
            exp_tag_q <= '0;
        end else begin
            if (st.enter[STG_F]) begin
                killed_q[idx_f] <= 1'b0;
            end
            if (st.kill_fd != 2'd0) begin
                if (st.occ[STG_F]) begin
                    killed_q[idx_f] <= 1'b1;
                end
                if (st.occ[STG_D]) begin
                    killed_q[idx_d] <= 1'b1;
                end
            end
            if (rec_valid) begin
                exp_tag_q <= (rec.tag + tag_t'(1)) & TAG_MASK;
            end else if (killed_q[exp_tag_q[TAG_W-1:0]]) begin
                exp_tag_q <= (exp_tag_q + tag_t'(1)) & TAG_MASK;
            end
        end
    end

    a_rec_order: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> (rec.tag == exp_tag_q))
        else $error("record tag out of order");

endmodule

`default_nettype wire

// ==== hw/trace_pkg.sv ====
/*
 * trace record and statistics types
 * cycle stamps are 32 bits and wrap silently on very long runs
 * counters are 16 bits and stick at their maximum
 */
`default_nettype none

package trace_pkg;

    //////////////////////////////////////////////////
    // cycle stamps
    //////////////////////////////////////////////////

    typedef logic [31:0] cyc_t;

    //////////////////////////////////////////////////
    // statistics counters
    //////////////////////////////////////////////////

    localparam int CNT_W = 16;

    typedef logic [CNT_W-1:0] cnt_t;

    // saturation value for every counter
    localparam cnt_t CNT_MAX = '1;

    //////////////////////////////////////////////////
    // one record per retired instruction
    //////////////////////////////////////////////////

    // stall_cyc saturates at 255 held edges
    typedef struct packed {
        pipe_pkg::tag_t tag;
        cyc_t           fetch_cyc;
        cyc_t           decode_cyc;
        cyc_t           exec_cyc;
        cyc_t           mem_cyc;
        cyc_t           wb_cyc;
        logic [7:0]     stall_cyc;
    } trace_rec_t;

endpackage

`default_nettype wire

// ==== hw/trace_stats.sv ====
/*
 * retired, stall and flush counters
 * all three stick at their maximum and never wrap
 */
`timescale 1ns/1ns
`default_nettype none

module trace_stats import trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    stage_if.stats st,
    input  logic   rec_valid,
    output cnt_t   retired_cnt,
    output cnt_t   stall_cnt,
    output cnt_t   flush_cnt
);

    // add 0..3 with clamp at CNT_MAX
    function automatic cnt_t sat_add(input cnt_t base, input logic [1:0] inc);
        logic [CNT_W:0] sum;
        sum = {1'b0, base} + {{(CNT_W - 1){1'b0}}, inc};
        sat_add = sum[CNT_W] ? CNT_MAX : sum[CNT_W-1:0];
    endfunction

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_cnt <= '0;
            stall_cnt   <= '0;
            flush_cnt   <= '0;
        end else begin
            // one per record pulse
            retired_cnt <= sat_add(retired_cnt, {1'b0, rec_valid});
            // hold_fd already excludes stall under flush
            stall_cnt   <= sat_add(stall_cnt, {1'b0, st.hold_fd});
            // live instructions dropped on this edge
            flush_cnt   <= sat_add(flush_cnt, st.kill_fd);
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
hw/pipe_pkg.sv
hw/trace_pkg.sv
hw/stage_if.sv
hw/stage_tracker.sv
hw/stamp_store.sv
hw/trace_stats.sv
hw/pipe_trace_top.sv
verif/tb_pipe_trace.sv

// ==== verif/tb_trace_model.svh ====
/*
 * reference model of the trace unit, stepped once per clock edge
 * included inside the testbench module, which supplies TAG_W and TAG_MASK
 * tags stay below 2^TAG_W, so the tables are sized for the widest tag
 */
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// shadow pipeline as it stands in the current cycle
logic [NUM_STAGES-1:0] m_occ;
tag_t                  m_tag [NUM_STAGES];
tag_t                  m_next_tag;
cyc_t                  m_cyc;
// per-tag stamps and flush marks
trace_rec_t            m_tbl [1 << TAG_W_MAX];
logic                  m_killed [1 << TAG_W_MAX];
// expected outputs of the current cycle
logic                  m_rec_valid;
trace_rec_t            m_rec;
cnt_t                  m_retired;
cnt_t                  m_stalls;
cnt_t                  m_flushed;

// one more held edge, sticks at 255
function automatic logic [7:0] add_held_edge(input logic [7:0] cur);
    add_held_edge = (cur == 8'hff) ? cur : cur + 8'd1;
endfunction

// first cycle after reset: tag 0 sits in fetch with stamp 0
task automatic reset_model();
    m_occ        = '0;
    m_occ[STG_F] = 1'b1;
    m_tag[STG_F] = '0;
    m_next_tag   = tag_t'(1);
    m_cyc        = '0;
    m_tbl[0]     = '0;
    m_rec_valid  = 1'b0;
    m_retired    = '0;
    m_stalls     = '0;
    m_flushed    = '0;
    foreach (m_killed[i]) begin
        m_killed[i] = 1'b0;
    end
endtask

// one rising edge with the given stall and flush levels
task automatic advance_model(input logic stall_in, input logic flush_in);
    logic hold;
    logic plain;
    hold  = stall_in && !flush_in;
    plain = !stall_in && !flush_in;
    // held instructions gain one stall edge
    if (hold && m_occ[STG_F]) begin
        m_tbl[m_tag[STG_F]].stall_cyc = add_held_edge(m_tbl[m_tag[STG_F]].stall_cyc);
    end
    if (hold && m_occ[STG_D]) begin
        m_tbl[m_tag[STG_D]].stall_cyc = add_held_edge(m_tbl[m_tag[STG_D]].stall_cyc);
    end
    // counters take this cycle's record, hold and kill on the edge
    if (m_rec_valid) begin
        m_retired = m_retired + cnt_t'(1);
    end
    if (hold) begin
        m_stalls = m_stalls + cnt_t'(1);
    end
    if (flush_in) begin
        m_flushed = m_flushed + cnt_t'(m_occ[STG_F]) + cnt_t'(m_occ[STG_D]);
        if (m_occ[STG_F]) begin
            m_killed[m_tag[STG_F]] = 1'b1;
        end
        if (m_occ[STG_D]) begin
            m_killed[m_tag[STG_D]] = 1'b1;
        end
    end
    // write-back content shows up as next cycle's record
    m_rec_valid = m_occ[STG_W];
    if (m_occ[STG_W]) begin
        m_rec = m_tbl[m_tag[STG_W]];
    end
    m_cyc = m_cyc + cyc_t'(1);
    // memory and write-back always move on
    m_occ[STG_W] = m_occ[STG_M];
    m_tag[STG_W] = m_tag[STG_M];
    m_occ[STG_M] = m_occ[STG_E];
    m_tag[STG_M] = m_tag[STG_E];
    if (plain) begin
        m_occ[STG_E] = m_occ[STG_D];
        m_tag[STG_E] = m_tag[STG_D];
        m_occ[STG_D] = m_occ[STG_F];
        m_tag[STG_D] = m_tag[STG_F];
        m_occ[STG_F] = 1'b1;
        m_tag[STG_F] = m_next_tag;
        m_next_tag   = (m_next_tag + tag_t'(1)) & TAG_MASK;
        // fresh fetch entry
        m_tbl[m_tag[STG_F]]           = '0;
        m_tbl[m_tag[STG_F]].tag       = m_tag[STG_F];
        m_tbl[m_tag[STG_F]].fetch_cyc = m_cyc;
        m_killed[m_tag[STG_F]]        = 1'b0;
        if (m_occ[STG_D]) begin
            m_tbl[m_tag[STG_D]].decode_cyc = m_cyc;
        end
    end else begin
        // bubble into execute, a flush also empties fetch and decode
        m_occ[STG_E] = 1'b0;
        if (flush_in) begin
            m_occ[STG_F] = 1'b0;
            m_occ[STG_D] = 1'b0;
        end
    end
    // stamp = cyc of the first cycle in the stage
    if (m_occ[STG_E]) begin
        m_tbl[m_tag[STG_E]].exec_cyc = m_cyc;
    end
    if (m_occ[STG_M]) begin
        m_tbl[m_tag[STG_M]].mem_cyc = m_cyc;
    end
    if (m_occ[STG_W]) begin
        m_tbl[m_tag[STG_W]].wb_cyc = m_cyc;
    end
endtask

`endif

// ==== verif/tb_pipe_trace.sv ====
/*
 * testbench for the pipeline trace unit, TAG_W fixed at 4
 * every cycle is compared with the model at the falling edge
 * directed tests first, then 2000 random cycles from one seed
 */
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_trace import pipe_pkg::*; import trace_pkg::*; ();

    localparam int   TAG_W    = 4;
    localparam tag_t TAG_MASK = tag_t'((1 << TAG_W) - 1);
    // cycles allowed for a tag to reach the record port
    localparam int   TIMEOUT  = 40;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       flush;
    logic       rec_valid;
    tag_t       rec_tag;
    cyc_t       rec_fetch_cyc;
    cyc_t       rec_decode_cyc;
    cyc_t       rec_exec_cyc;
    cyc_t       rec_mem_cyc;
    cyc_t       rec_wb_cyc;
    logic [7:0] rec_stall_cyc;
    cnt_t       retired_cnt;
    cnt_t       stall_cnt;
    cnt_t       flush_cnt;
    trace_rec_t dut_rec;

    integer seed;
    integer rnd_stall;
    integer rnd_flush;
    int     errors;
    int     test_start;
    int     tests_failed;
    int     recs;
    logic   plain_flow;
    tag_t   prev_tag;
    tag_t   watch_tag;
    cnt_t   cnt_before;

    `include "tb_trace_model.svh"

    always #5 clk = ~clk;

    pipe_trace_top #(.TAG_W(TAG_W)) i_dut (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .flush          (flush),
        .rec_valid      (rec_valid),
        .rec_tag        (rec_tag),
        .rec_fetch_cyc  (rec_fetch_cyc),
        .rec_decode_cyc (rec_decode_cyc),
        .rec_exec_cyc   (rec_exec_cyc),
        .rec_mem_cyc    (rec_mem_cyc),
        .rec_wb_cyc     (rec_wb_cyc),
        .rec_stall_cyc  (rec_stall_cyc),
        .retired_cnt    (retired_cnt),
        .stall_cnt      (stall_cnt),
        .flush_cnt      (flush_cnt)
    );

    // plain record ports packed back into the record type
    assign dut_rec = {rec_tag, rec_fetch_cyc, rec_decode_cyc, rec_exec_cyc,
                      rec_mem_cyc, rec_wb_cyc, rec_stall_cyc};

    //////////////////////////////////////////////////
    // compares
    //////////////////////////////////////////////////

    task automatic compare_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_rec(input trace_rec_t got, input trace_rec_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t rec got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    // without stalls a record is five back-to-back stamps, one cycle late
    task automatic plain_timing();
        if (rec_tag != ((prev_tag + tag_t'(1)) & TAG_MASK)
            || rec_decode_cyc != rec_fetch_cyc + 32'd1
            || rec_exec_cyc != rec_fetch_cyc + 32'd2
            || rec_mem_cyc != rec_fetch_cyc + 32'd3
            || rec_wb_cyc != rec_fetch_cyc + 32'd4
            || rec_stall_cyc != 8'd0
            || rec_wb_cyc != m_cyc - 32'd1) begin
            errors++;
            $display("record for tag %0d breaks plain-flow timing at t=%0t", rec_tag, $time);
        end
        prev_tag = rec_tag;
    endtask

    task automatic compare_cycle();
        compare_strobe("rec_valid", rec_valid, m_rec_valid);
        if (rec_valid && m_rec_valid) begin
            recs++;
            check_rec(dut_rec, m_rec);
            if (m_killed[rec_tag]) begin
                errors++;
                $display("flushed tag %0d came out as a record at t=%0t", rec_tag, $time);
            end
            if (plain_flow) begin
                plain_timing();
            end
        end
        check_cnt("retired_cnt", retired_cnt, m_retired);
        check_cnt("stall_cnt", stall_cnt, m_stalls);
        check_cnt("flush_cnt", flush_cnt, m_flushed);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // called at a falling edge, returns at the next one
    task automatic step(input logic stall_in, input logic flush_in);
        compare_cycle();
        stall = stall_in;
        flush = flush_in;
        advance_model(stall_in, flush_in);
        @(negedge clk);
    endtask

    // plain cycles until the tag is on the record port
    task automatic wait_tag(input tag_t t, input int limit);
        int n;
        n = 0;
        while (!(rec_valid && rec_tag == t) && n < limit) begin
            step(1'b0, 1'b0);
            n++;
        end
        if (!(rec_valid && rec_tag == t)) begin
            errors++;
            $display("timeout: tag %0d did not retire within %0d cycles", t, limit);
        end
    endtask

    task automatic close_test(input int num, input string name);
        if (errors == test_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        seed         = 32'hdb112e60;
        errors       = 0;
        test_start   = 0;
        tests_failed = 0;
        recs         = 0;
        plain_flow   = 1'b0;
        prev_tag     = TAG_MASK;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        reset_model();

        // tags wrap twice in 40 plain cycles
        plain_flow = 1'b1;
        repeat (40) step(1'b0, 1'b0);
        plain_flow = 1'b0;
        if (recs < 30) begin
            errors++;
            $display("only %0d records in 40 plain cycles", recs);
        end
        close_test(1, "plain flow");

        // one stall, then three held edges on a fresh fetch tag
        step(1'b1, 1'b0);
        repeat (4) step(1'b0, 1'b0);
        watch_tag = m_tag[STG_F];
        repeat (3) step(1'b1, 1'b0);
        wait_tag(watch_tag, TIMEOUT);
        if (rec_valid && rec_tag == watch_tag) begin
            if (rec_stall_cyc != 8'd3) begin
                errors++;
                $display("FAILED t=%0t rec_stall_cyc got=%0d exp=3", $time, rec_stall_cyc);
            end
            if (rec_wb_cyc != rec_fetch_cyc + 32'd7) begin
                errors++;
                $display("FAILED t=%0t rec_wb_cyc got=%0d exp=%0d", $time, rec_wb_cyc,
                         rec_fetch_cyc + 32'd7);
            end
        end
        close_test(2, "stalls");

        // full fetch and decode dropped, next tag retires
        repeat (3) step(1'b0, 1'b0);
        cnt_before = m_flushed;
        watch_tag  = m_next_tag;
        step(1'b0, 1'b1);
        check_cnt("flush_cnt", flush_cnt, cnt_before + cnt_t'(2));
        wait_tag(watch_tag, TIMEOUT);
        close_test(3, "flush");

        // flush wins, the stall edge is not counted
        repeat (3) step(1'b0, 1'b0);
        cnt_before = m_stalls;
        step(1'b1, 1'b1);
        check_cnt("stall_cnt", stall_cnt, cnt_before);
        close_test(4, "stall with flush");

        // about 20% stall and 5% flush
        for (int i = 0; i < 2000; i++) begin
            rnd_stall = $random(seed);
            rnd_flush = $random(seed);
            step(({rnd_stall} % 100) < 20, ({rnd_flush} % 100) < 5);
        end
        compare_cycle();
        close_test(5, "random");

        $display("tests 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
